/* hw/ofdm_pkg.sv */
package ofdm_pkg;

    // log2 of the FFT length
    localparam int NFFT_DEFAULT = 4;
    // cyclic prefix in samples
    localparam int CP_LEN_DEFAULT = 4;
    // window opens this many samples before the prefix ends
    localparam int CP_ADVANCE_DEFAULT = 3;
    localparam int SYMS_PER_BURST_DEFAULT = 4;

    function automatic int fft_len(input int nfft);
        return 1 << nfft;
    endfunction

    // samples per symbol, prefix included
    function automatic int sym_len(input int nfft, input int cp_len);
        return fft_len(nfft) + cp_len;
    endfunction

    localparam int FFT_LEN_DEFAULT = fft_len(NFFT_DEFAULT);
    localparam int SYM_LEN_DEFAULT = sym_len(NFFT_DEFAULT, CP_LEN_DEFAULT);

endpackage

/* hw/sample_pkg.sv */
package sample_pkg;

    // one real or imaginary component
    localparam int COMP_W = 16;
    // imaginary in the upper half, real in the lower half
    localparam int SAMPLE_W = 2 * COMP_W;
    // unity in Q1.15, one LSB short of 1.0
    localparam int COEF_ONE = (1 << (COMP_W - 1)) - 1;
    localparam real PI = 3.14159265358979;

    // clamp a widened component back into COMP_W bits
    function automatic logic [COMP_W-1:0] sat_comp(input logic signed [2*COMP_W:0] x);
        if (x > COEF_ONE) begin
            return COMP_W'(COEF_ONE);
        end else if (x < -COEF_ONE - 1) begin
            return COMP_W'(-COEF_ONE - 1);
        end
        return x[COMP_W-1:0];
    endfunction

    // a times b with b in Q1.15, rounded half up per component
    function automatic logic [SAMPLE_W-1:0] cmul_round(
        input logic [SAMPLE_W-1:0] a,
        input logic [SAMPLE_W-1:0] b
    );
        logic signed [COMP_W-1:0] a_re;
        logic signed [COMP_W-1:0] a_im;
        logic signed [COMP_W-1:0] b_re;
        logic signed [COMP_W-1:0] b_im;
        logic signed [2*COMP_W:0] p_re;
        logic signed [2*COMP_W:0] p_im;
        a_re = a[COMP_W-1:0];
        a_im = a[SAMPLE_W-1:COMP_W];
        b_re = b[COMP_W-1:0];
        b_im = b[SAMPLE_W-1:COMP_W];
        p_re = (a_re * b_re - a_im * b_im + (1 << (COMP_W - 2))) >>> (COMP_W - 1);
        p_im = (a_re * b_im + a_im * b_re + (1 << (COMP_W - 2))) >>> (COMP_W - 1);
        return {sat_comp(p_im), sat_comp(p_re)};
    endfunction

endpackage

/* hw/cp_remover.sv */
`timescale 1ns/100ps

module cp_remover #(
    parameter int NFFT           = ofdm_pkg::NFFT_DEFAULT,
    parameter int CP_LEN         = ofdm_pkg::CP_LEN_DEFAULT,
    parameter int CP_ADVANCE     = ofdm_pkg::CP_ADVANCE_DEFAULT,
    parameter int SYMS_PER_BURST = ofdm_pkg::SYMS_PER_BURST_DEFAULT
) (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  logic [sample_pkg::SAMPLE_W-1:0] in_data_i,
    input  logic                            in_valid_i,
    input  logic                            burst_start_i,
    output logic [sample_pkg::SAMPLE_W-1:0] win_data_o,
    output logic                            win_valid_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_PREFIX,
        S_WINDOW,
        S_TAIL
    } state_t;

    localparam int N = ofdm_pkg::fft_len(NFFT);
    localparam int PRE_LEN = CP_LEN - CP_ADVANCE;
    localparam int CNT_W = $clog2(ofdm_pkg::sym_len(NFFT, CP_LEN));
    localparam int SYM_W = (SYMS_PER_BURST > 1) ? $clog2(SYMS_PER_BURST) : 1;
    // with nothing to discard a symbol starts straight in the window
    localparam state_t FIRST_STATE = (PRE_LEN > 0) ? S_PREFIX : S_WINDOW;

    state_t           state;
    state_t           cur_state;
    logic [CNT_W-1:0] seg_cnt;
    logic [CNT_W-1:0] seg_end;
    logic [SYM_W-1:0] sym_cnt;
    logic             seg_last;
    logic             sym_last;

    always_comb begin
        // the burst start pulse rides on the first prefix sample
        cur_state = state;
        if (state == S_IDLE && burst_start_i) begin
            cur_state = FIRST_STATE;
        end
        case (cur_state)
            S_PREFIX: seg_end = CNT_W'(PRE_LEN - 1);
            S_WINDOW: seg_end = CNT_W'(N - 1);
            S_TAIL:   seg_end = CNT_W'(CP_ADVANCE - 1);
            default:  seg_end = '0;
        endcase
        seg_last = (seg_cnt == seg_end);
        // no tail when the window is not early
        sym_last = seg_last && (cur_state == S_TAIL ||
                   (cur_state == S_WINDOW && CP_ADVANCE == 0));
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state       <= S_IDLE;
            seg_cnt     <= '0;
            sym_cnt     <= '0;
            win_valid_o <= 1'b0;
        end else begin
            win_valid_o <= in_valid_i && (cur_state == S_WINDOW);
            if (in_valid_i && cur_state != S_IDLE) begin
                if (!seg_last) begin
                    seg_cnt <= seg_cnt + 1'b1;
                    state   <= cur_state;
                end else begin
                    seg_cnt <= '0;
                    if (sym_last) begin
                        if (sym_cnt == SYM_W'(SYMS_PER_BURST - 1)) begin
                            sym_cnt <= '0;
                            state   <= S_IDLE;
                        end else begin
                            sym_cnt <= sym_cnt + 1'b1;
                            state   <= FIRST_STATE;
                        end
                    end else if (cur_state == S_PREFIX) begin
                        state <= S_WINDOW;
                    end else begin
                        state <= S_TAIL;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        win_data_o <= in_data_i;
    end

    // FFT stages shift every cycle, so a window must arrive without gaps
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        (state == S_WINDOW && seg_cnt != '0) |-> in_valid_i);

endmodule

/* hw/fft_sdf_stage.sv */
`timescale 1ns/100ps

module fft_sdf_stage #(
    parameter int NFFT  = ofdm_pkg::NFFT_DEFAULT,
    parameter int STAGE = 0
) (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  logic [sample_pkg::SAMPLE_W-1:0] in_data_i,
    input  logic                            in_valid_i,
    output logic [sample_pkg::SAMPLE_W-1:0] out_data_o,
    output logic                            out_valid_o
);

    localparam int CW = sample_pkg::COMP_W;
    localparam int SW = sample_pkg::SAMPLE_W;
    // butterfly span, half the block length
    localparam int D = ofdm_pkg::fft_len(NFFT - STAGE - 1);
    localparam int BLK_W = NFFT - STAGE;
    localparam int TW_W = (D > 1) ? $clog2(D) : 1;

    logic [BLK_W-1:0]     blk_cnt;
    logic [SW-1:0]        dl_data [D];
    logic [D-1:0]         dl_diff;
    logic [TW_W-1:0]      tw_idx;
    logic [SW-1:0]        tw_rom [D];
    logic [SW-1:0]        fb_data;
    logic [SW-1:0]        sum_data;
    logic [SW-1:0]        dif_data;
    logic                 upper;
    logic signed [CW-1:0] a_re;
    logic signed [CW-1:0] a_im;
    logic signed [CW-1:0] b_re;
    logic signed [CW-1:0] b_im;
    logic signed [CW:0]   sum_re;
    logic signed [CW:0]   sum_im;
    logic signed [CW:0]   dif_re;
    logic signed [CW:0]   dif_im;

    // W of 2D to the power j
    initial begin
        real ang;
        int  w_re;
        int  w_im;
        for (int j = 0; j < D; j++) begin
            ang = sample_pkg::PI * real'(j) / real'(D);
            w_re = int'($cos(ang) * real'(sample_pkg::COEF_ONE));
            w_im = int'(-$sin(ang) * real'(sample_pkg::COEF_ONE));
            tw_rom[j] = {w_im[CW-1:0], w_re[CW-1:0]};
        end
    end

    assign fb_data = dl_data[D-1];
    // second half of a block pairs x[n+D] with the stored x[n]
    assign upper = in_valid_i && blk_cnt[BLK_W-1];

    assign a_re = fb_data[CW-1:0];
    assign a_im = fb_data[SW-1:CW];
    assign b_re = in_data_i[CW-1:0];
    assign b_im = in_data_i[SW-1:CW];

    assign sum_re = a_re + b_re;
    assign sum_im = a_im + b_im;
    assign dif_re = a_re - b_re;
    assign dif_im = a_im - b_im;
    // halved per stage
    assign sum_data = {sum_im[CW:1], sum_re[CW:1]};
    assign dif_data = {dif_im[CW:1], dif_re[CW:1]};

    always_ff @(posedge clk_i) begin
        for (int i = D - 1; i > 0; i--) begin
            dl_data[i] <= dl_data[i-1];
        end
        dl_data[0] <= upper ? dif_data : in_data_i;
        out_data_o <= upper ? sum_data : sample_pkg::cmul_round(fb_data, tw_rom[tw_idx]);
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            blk_cnt     <= '0;
            dl_diff     <= '0;
            tw_idx      <= '0;
            out_valid_o <= 1'b0;
        end else begin
            if (in_valid_i) begin
                blk_cnt <= blk_cnt + 1'b1;
            end
            // marks which delay line entries hold differences
            for (int i = D - 1; i > 0; i--) begin
                dl_diff[i] <= dl_diff[i-1];
            end
            dl_diff[0] <= upper;
            out_valid_o <= upper || dl_diff[D-1];
            if (dl_diff[D-1]) begin
                tw_idx <= (tw_idx == TW_W'(D - 1)) ? '0 : tw_idx + 1'b1;
            end
        end
    end

    // holds only while every block arrives without gaps
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_valid_o |-> $past(in_valid_i, D + 1));

endmodule

/* hw/cp_phase_rotator.sv */
`timescale 1ns/100ps

module cp_phase_rotator #(
    parameter int NFFT       = ofdm_pkg::NFFT_DEFAULT,
    parameter int CP_ADVANCE = ofdm_pkg::CP_ADVANCE_DEFAULT
) (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  logic [sample_pkg::SAMPLE_W-1:0] in_data_i,
    input  logic                            in_valid_i,
    output logic [sample_pkg::SAMPLE_W-1:0] out_data_o,
    output logic                            out_valid_o,
    output logic [NFFT-1:0]                 bin_o
);

    localparam int N = ofdm_pkg::fft_len(NFFT);
    localparam int CW = sample_pkg::COMP_W;
    localparam int SW = sample_pkg::SAMPLE_W;

    logic [NFFT-1:0] pos_cnt;
    logic [NFFT-1:0] bin_now;
    logic [NFFT-1:0] bin_q;
    logic            valid_q;

    // SDF output comes in bit-reversed order
    always_comb begin
        for (int i = 0; i < NFFT; i++) begin
            bin_now[i] = pos_cnt[NFFT-1-i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pos_cnt     <= '0;
            valid_q     <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            if (in_valid_i) begin
                pos_cnt <= pos_cnt + 1'b1;
            end
            valid_q     <= in_valid_i;
            out_valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        bin_q <= bin_now;
        bin_o <= bin_q;
    end

    if (CP_ADVANCE != 0) begin : g_rotate
        logic [SW-1:0] rot_rom [N];
        logic [SW-1:0] data_q;
        logic [SW-1:0] coef_q;

        // early window shows up as exp(-j*2pi*k*adv/N), so rotate it back
        initial begin
            real ang;
            int  c_re;
            int  c_im;
            for (int k = 0; k < N; k++) begin
                ang = 2.0 * sample_pkg::PI * real'((k * CP_ADVANCE) % N) / real'(N);
                c_re = int'($cos(ang) * real'(sample_pkg::COEF_ONE));
                c_im = int'($sin(ang) * real'(sample_pkg::COEF_ONE));
                rot_rom[k] = {c_im[CW-1:0], c_re[CW-1:0]};
            end
        end

        always_ff @(posedge clk_i) begin
            data_q     <= in_data_i;
            coef_q     <= rot_rom[bin_now];
            out_data_o <= sample_pkg::cmul_round(data_q, coef_q);
        end
    end else begin : g_bypass
        logic [SW-1:0] data_q;

        // same two cycles as the multiply path
        always_ff @(posedge clk_i) begin
            data_q     <= in_data_i;
            out_data_o <= data_q;
        end
    end

endmodule

/* hw/symbol_framer.sv */
`timescale 1ns/100ps

module symbol_framer #(
    parameter int NFFT           = ofdm_pkg::NFFT_DEFAULT,
    parameter int SYMS_PER_BURST = ofdm_pkg::SYMS_PER_BURST_DEFAULT
) (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  logic [sample_pkg::SAMPLE_W-1:0] in_data_i,
    input  logic                            in_valid_i,
    input  logic [NFFT-1:0]                 bin_i,
    output logic [sample_pkg::SAMPLE_W-1:0] out_data_o,
    output logic                            out_valid_o,
    output logic [NFFT-1:0]                 out_bin_o,
    output logic                            symbol_start_o,
    output logic                            pbch_valid_o,
    output logic                            sss_valid_o
);

    localparam int N = ofdm_pkg::fft_len(NFFT);
    localparam int SYM_W = (SYMS_PER_BURST > 1) ? $clog2(SYMS_PER_BURST) : 1;

    logic [NFFT-1:0]  pos_cnt;
    logic [SYM_W-1:0] sym_cnt;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pos_cnt        <= '0;
            sym_cnt        <= '0;
            out_valid_o    <= 1'b0;
            symbol_start_o <= 1'b0;
            pbch_valid_o   <= 1'b0;
            sss_valid_o    <= 1'b0;
        end else begin
            out_valid_o    <= in_valid_i;
            symbol_start_o <= in_valid_i && (pos_cnt == '0);
            // symbol 0 carries PBCH, symbol 1 carries SSS
            pbch_valid_o   <= in_valid_i && (sym_cnt == SYM_W'(0));
            sss_valid_o    <= in_valid_i && (SYMS_PER_BURST > 1) && (sym_cnt == SYM_W'(1));
            if (in_valid_i) begin
                pos_cnt <= pos_cnt + 1'b1;
                if (pos_cnt == NFFT'(N - 1)) begin
                    sym_cnt <= (sym_cnt == SYM_W'(SYMS_PER_BURST - 1)) ? '0 : sym_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        out_data_o <= in_data_i;
        out_bin_o  <= bin_i;
    end

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        !(pbch_valid_o && sss_valid_o));

    // rotator bin count and symbol count must stay in step
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        symbol_start_o |-> (out_bin_o == '0));

endmodule

/* hw/ofdm_demod.sv */
`timescale 1ns/100ps

module ofdm_demod #(
    parameter int NFFT           = ofdm_pkg::NFFT_DEFAULT,
    parameter int CP_LEN         = ofdm_pkg::CP_LEN_DEFAULT,
    parameter int CP_ADVANCE     = ofdm_pkg::CP_ADVANCE_DEFAULT,
    parameter int SYMS_PER_BURST = ofdm_pkg::SYMS_PER_BURST_DEFAULT
) (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  logic [sample_pkg::SAMPLE_W-1:0] in_data_i,
    input  logic                            in_valid_i,
    input  logic                            burst_start_i,
    output logic [sample_pkg::SAMPLE_W-1:0] out_data_o,
    output logic                            out_valid_o,
    output logic [NFFT-1:0]                 out_bin_o,
    output logic                            symbol_start_o,
    output logic                            pbch_valid_o,
    output logic                            sss_valid_o
);

    localparam int SW = sample_pkg::SAMPLE_W;

    logic [SW-1:0]   win_data;
    logic            win_valid;
    logic [SW-1:0]   stage_data [NFFT];
    logic [NFFT-1:0] stage_valid;
    logic [SW-1:0]   rot_data;
    logic            rot_valid;
    logic [NFFT-1:0] rot_bin;

    cp_remover #(
        .NFFT           (NFFT),
        .CP_LEN         (CP_LEN),
        .CP_ADVANCE     (CP_ADVANCE),
        .SYMS_PER_BURST (SYMS_PER_BURST)
    ) u_cp_remover (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .in_data_i     (in_data_i),
        .in_valid_i    (in_valid_i),
        .burst_start_i (burst_start_i),
        .win_data_o    (win_data),
        .win_valid_o   (win_valid)
    );

    // radix-2 DIF, span halves each stage
    for (genvar s = 0; s < NFFT; s++) begin : g_stage
        logic [SW-1:0] st_data;
        logic          st_valid;

        if (s == 0) begin : g_first
            assign st_data  = win_data;
            assign st_valid = win_valid;
        end else begin : g_next
            assign st_data  = stage_data[s-1];
            assign st_valid = stage_valid[s-1];
        end

        fft_sdf_stage #(
            .NFFT  (NFFT),
            .STAGE (s)
        ) u_stage (
            .clk_i       (clk_i),
            .reset_ni    (reset_ni),
            .in_data_i   (st_data),
            .in_valid_i  (st_valid),
            .out_data_o  (stage_data[s]),
            .out_valid_o (stage_valid[s])
        );
    end

    cp_phase_rotator #(
        .NFFT       (NFFT),
        .CP_ADVANCE (CP_ADVANCE)
    ) u_rotator (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_data_i   (stage_data[NFFT-1]),
        .in_valid_i  (stage_valid[NFFT-1]),
        .out_data_o  (rot_data),
        .out_valid_o (rot_valid),
        .bin_o       (rot_bin)
    );

    symbol_framer #(
        .NFFT           (NFFT),
        .SYMS_PER_BURST (SYMS_PER_BURST)
    ) u_framer (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .in_data_i      (rot_data),
        .in_valid_i     (rot_valid),
        .bin_i          (rot_bin),
        .out_data_o     (out_data_o),
        .out_valid_o    (out_valid_o),
        .out_bin_o      (out_bin_o),
        .symbol_start_o (symbol_start_o),
        .pbch_valid_o   (pbch_valid_o),
        .sss_valid_o    (sss_valid_o)
    );

endmodule

/* tests/ofdm_demod_tb.sv */
`timescale 1ns/100ps

module ofdm_demod_tb;

    localparam int NFFT = ofdm_pkg::NFFT_DEFAULT;
    localparam int N = 1 << NFFT;
    localparam int CP_LEN = ofdm_pkg::CP_LEN_DEFAULT;
    localparam int CP_ADVANCE = ofdm_pkg::CP_ADVANCE_DEFAULT;
    localparam int SYMS = ofdm_pkg::SYMS_PER_BURST_DEFAULT;
    localparam int SW = sample_pkg::SAMPLE_W;
    localparam int CW = sample_pkg::COMP_W;
    localparam int BURSTS = 3;
    localparam int SYM_SAMPLES = CP_LEN + N;
    // first window sample, counted from the start of a symbol
    localparam int WIN_FIRST = CP_LEN - CP_ADVANCE;
    localparam int LATENCY = N + NFFT + 3;
    localparam int AMP = 12000;
    localparam int TOL = 8;
    localparam int TIMEOUT_CYCLES = BURSTS * SYMS * SYM_SAMPLES * 3 + 200;
    localparam real TWO_PI = 6.283185307179586;
    localparam logic [31:0] SEED = 32'h1c99c4e7;

    logic            clk_i;
    logic            reset_ni;
    logic [SW-1:0]   in_data_i;
    logic            in_valid_i;
    logic            burst_start_i;
    logic [SW-1:0]   out_data_o;
    logic            out_valid_o;
    logic [NFFT-1:0] out_bin_o;
    logic            symbol_start_o;
    logic            pbch_valid_o;
    logic            sss_valid_o;

    logic [31:0] rng_state;
    int          cyc = 0;
    bit          bursts_started = 1'b0;
    bit          in_burst = 1'b0;
    int          in_samp = 0;
    int          in_sym = 0;
    // one entry per symbol in flight
    int          first_q[$];
    int          sym_q[$];
    int          tone_q[$];
    int          out_pos = 0;
    int          out_sym = 0;
    int          out_tone = 0;

    ofdm_demod dut (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .in_data_i      (in_data_i),
        .in_valid_i     (in_valid_i),
        .burst_start_i  (burst_start_i),
        .out_data_o     (out_data_o),
        .out_valid_o    (out_valid_o),
        .out_bin_o      (out_bin_o),
        .symbol_start_o (symbol_start_o),
        .pbch_valid_o   (pbch_valid_o),
        .sss_valid_o    (sss_valid_o)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    function automatic logic [NFFT-1:0] bit_reverse(input int pos);
        logic [NFFT-1:0] p;
        logic [NFFT-1:0] r;
        p = NFFT'(pos);
        for (int i = 0; i < NFFT; i++) begin
            r[i] = p[NFFT-1-i];
        end
        return r;
    endfunction

    // A * exp(j*2pi*m*n/N)
    function automatic logic [SW-1:0] tone_sample(input int m, input int n);
        real ang;
        int  re;
        int  im;
        ang = TWO_PI * real'((m * n) % N) / real'(N);
        re = int'(real'(AMP) * $cos(ang));
        im = int'(real'(AMP) * $sin(ang));
        return {im[CW-1:0], re[CW-1:0]};
    endfunction

    function automatic bit near(input int value, input int target);
        return (value - target <= TOL) && (target - value <= TOL);
    endfunction

    task automatic report_failure(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic drive_cycle(input logic [SW-1:0] data, input logic valid,
                               input logic start);
        @(negedge clk_i);
        in_data_i     = data;
        in_valid_i    = valid;
        burst_start_i = start;
    endtask

    task automatic send_symbol(input bit first);
        logic [31:0] r;
        int          m;
        int          n;
        draw_random(r);
        m = int'(r % N);
        tone_q.push_back(m);
        for (int t = 0; t < SYM_SAMPLES; t++) begin
            draw_random(r);
            // single-cycle gaps only where they cannot split a window
            if ((t <= WIN_FIRST || t >= WIN_FIRST + N) && r[1:0] == 2'b00) begin
                drive_cycle(~r, 1'b0, 1'b0);
            end
            n = (t - CP_LEN + N) % N;
            if (t < WIN_FIRST) begin
                // prefix samples that the window must skip
                draw_random(r);
                drive_cycle(r, 1'b1, first && t == 0);
            end else begin
                drive_cycle(tone_sample(m, n), 1'b1, first && t == 0);
            end
        end
    endtask

    // junk between bursts, valid on some cycles
    task automatic send_idle(input int cycles);
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            draw_random(r);
            drive_cycle(r, r[0], 1'b0);
        end
    endtask

    // input side count of valid samples, gives the edge of each first window sample
    always @(posedge clk_i) begin
        cyc = cyc + 1;
        if (reset_ni && in_valid_i) begin
            if (!in_burst && burst_start_i) begin
                in_burst = 1'b1;
                bursts_started = 1'b1;
                in_samp = 0;
                in_sym = 0;
            end
            if (in_burst) begin
                if (in_samp == WIN_FIRST) begin
                    first_q.push_back(cyc + LATENCY);
                    sym_q.push_back(in_sym);
                end
                in_samp++;
                if (in_samp == SYM_SAMPLES) begin
                    in_samp = 0;
                    in_sym++;
                    if (in_sym == SYMS) begin
                        in_burst = 1'b0;
                    end
                end
            end
        end
    end

    // outputs are settled at the falling edge, taken at the next rising edge
    always @(negedge clk_i) begin
        int re;
        int im;
        if (reset_ni) begin
            if (out_valid_o) begin
                if (out_pos == 0) begin
                    assert (first_q.size() != 0)
                        else report_failure("output valid with no symbol in flight");
                    assert (cyc + 1 == first_q[0])
                        else report_failure($sformatf("first output at cycle %0d, expected %0d",
                                                      cyc + 1, first_q[0]));
                    void'(first_q.pop_front());
                    out_sym = sym_q.pop_front();
                    out_tone = tone_q.pop_front();
                end
                assert (symbol_start_o == (out_pos == 0))
                    else report_failure($sformatf("symbol_start_o wrong at position %0d", out_pos));
                assert (out_bin_o == bit_reverse(out_pos))
                    else report_failure($sformatf("bin %0d at position %0d", out_bin_o, out_pos));
                assert (pbch_valid_o == (out_sym == 0))
                    else report_failure($sformatf("pbch_valid_o wrong in symbol %0d", out_sym));
                assert (sss_valid_o == (out_sym == 1))
                    else report_failure($sformatf("sss_valid_o wrong in symbol %0d", out_sym));
                re = int'($signed(out_data_o[CW-1:0]));
                im = int'($signed(out_data_o[SW-1:CW]));
                if (int'(out_bin_o) == out_tone) begin
                    assert (near(re, AMP) && near(im, 0))
                        else report_failure($sformatf("tone bin %0d is (%0d, %0d), expected (%0d, 0)",
                                                      out_tone, re, im, AMP));
                end else begin
                    assert (near(re, 0) && near(im, 0))
                        else report_failure($sformatf("bin %0d is (%0d, %0d), expected zero",
                                                      out_bin_o, re, im));
                end
                out_pos = (out_pos == N - 1) ? 0 : out_pos + 1;
            end else begin
                assert (out_pos == 0)
                    else report_failure($sformatf("gap after position %0d of a symbol", out_pos));
                // a symbol whose first output is due must not be missing
                if (first_q.size() != 0) begin
                    assert (cyc + 1 < first_q[0])
                        else report_failure($sformatf("no first output at cycle %0d",
                                                      first_q[0]));
                end
            end
        end
    end

    // nothing leaves the DUT before the first burst
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        !bursts_started |-> !(out_valid_o || symbol_start_o || pbch_valid_o || sss_valid_o))
        else report_failure("output activity before the first burst");

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        (symbol_start_o || pbch_valid_o || sss_valid_o) |-> out_valid_o)
        else report_failure("framing flag without a valid output");

    initial begin
        clk_i = 1'b0;
        reset_ni = 1'b0;
        in_data_i = '0;
        in_valid_i = 1'b0;
        burst_start_i = 1'b0;
        rng_state = SEED;
        repeat (5) @(negedge clk_i);
        reset_ni = 1'b1;
        // longer than the pipeline, so a start without burst_start_i would show
        send_idle(2 * LATENCY);
        for (int b = 0; b < BURSTS; b++) begin
            for (int s = 0; s < SYMS; s++) begin
                send_symbol(s == 0);
            end
            send_idle(3 + 2 * b);
        end
        drive_cycle('0, 1'b0, 1'b0);
        while (first_q.size() != 0 || out_pos != 0) begin
            @(posedge clk_i);
        end
        // idle inputs after the drain must leave the outputs quiet
        send_idle(2 * LATENCY);
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("watchdog: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $fatal(1);
    end

endmodule

/* src.f */
hw/ofdm_pkg.sv
hw/sample_pkg.sv
hw/cp_remover.sv
hw/fft_sdf_stage.sv
hw/cp_phase_rotator.sv
hw/symbol_framer.sv
hw/ofdm_demod.sv
tests/ofdm_demod_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the ofdm_demod testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module ofdm_demod_tb \
    -Mdir obj_dir -o ofdm_demod_tb \
    -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/ofdm_demod_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation run completed"
exit 0
